/* rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath and register file sizes
`define XLEN        32
`define REG_COUNT   32
`define REG_IDX_W   5

// Pending-write counter, three writes in flight at most
`define PEND_W      2

// Slots between execute and register write
`define WB_STAGES   2

// Major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011

// funct3 / funct7 encodings
`define F3_ADD      3'b000
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F7_SUB      7'b0100000

`endif

/* rv_arch_pkg.sv */
`include "rv_consts.svh"

package rv_arch_pkg;

    // ----------------------------------------
    // Instruction word views
    // ----------------------------------------

    // Register-register format
    typedef struct packed {
        logic [6:0]              funct7;
        logic [`REG_IDX_W-1:0]   rs2;
        logic [`REG_IDX_W-1:0]   rs1;
        logic [2:0]              funct3;
        logic [`REG_IDX_W-1:0]   rd;
        logic [6:0]              opcode;
    } instr_r_t;

    // Register-immediate format
    // 12-bit immediate sits where funct7 and rs2 sit in R-type
    typedef struct packed {
        logic [11:0]             imm;
        logic [`REG_IDX_W-1:0]   rs1;
        logic [2:0]              funct3;
        logic [`REG_IDX_W-1:0]   rd;
        logic [6:0]              opcode;
    } instr_i_t;

    // One 32-bit word, two decodings
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

/* rv_pipe_pkg.sv */
package rv_pipe_pkg;

    // ----------------------------------------
    // ALU operation select
    // ----------------------------------------

    // Immediate forms reuse the same codes,
    // the operand mux is steered separately
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

    // Codes 5..7 unused
    // Decoder never emits them

endpackage

/* instr_decoder.sv */
`include "rv_consts.svh"

module instr_decoder
    import rv_arch_pkg::*;
    import rv_pipe_pkg::*;
(
    input  instr_u                 instr_i,
    input  logic                   instr_valid_i,

    output logic [`REG_IDX_W-1:0]  rs1_idx_o,
    output logic [`REG_IDX_W-1:0]  rs2_idx_o,
    output logic [`REG_IDX_W-1:0]  rd_idx_o,
    output logic                   read_rs1_o,
    output logic                   read_rs2_o,
    output logic                   wr_en_o,
    output alu_op_e                alu_op_o,
    output logic                   use_imm_o,
    output logic [`XLEN-1:0]       imm_o
);

    // Set when the word is one of the supported encodings
    logic legal;
    logic is_r;

    // funct3 to ALU op, shared by both formats
    function automatic alu_op_e f3_to_op(input logic [2:0] f3);
        alu_op_e op;
        case (f3)
            `F3_XOR: op = ALU_XOR;
            `F3_OR:  op = ALU_OR;
            `F3_AND: op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    // ----------------------------------------
    // Format decode
    // ----------------------------------------
    always_comb begin
        legal     = 1'b0;
        is_r      = 1'b0;
        alu_op_o  = ALU_ADD;
        use_imm_o = 1'b0;
        imm_o     = '0;
        // Index fields share bit positions in both views
        rs1_idx_o = instr_i.r.rs1;
        rs2_idx_o = instr_i.r.rs2;
        rd_idx_o  = instr_i.r.rd;

        case (instr_i.r.opcode)
            `OPC_OP: begin
                is_r     = 1'b1;
                alu_op_o = f3_to_op(instr_i.r.funct3);
                case (instr_i.r.funct3)
                    `F3_ADD: begin
                        // funct7 picks ADD or SUB
                        if (instr_i.r.funct7 == '0) begin
                            legal = 1'b1;
                        end else if (instr_i.r.funct7 == `F7_SUB) begin
                            legal    = 1'b1;
                            alu_op_o = ALU_SUB;
                        end
                    end
                    `F3_XOR, `F3_OR, `F3_AND: legal = (instr_i.r.funct7 == '0);
                    default: legal = 1'b0;
                endcase
            end
            `OPC_OP_IMM: begin
                use_imm_o = 1'b1;
                alu_op_o  = f3_to_op(instr_i.i.funct3);
                // Sign-extend the 12-bit immediate
                imm_o     = {{(`XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
                case (instr_i.i.funct3)
                    `F3_ADD, `F3_XOR, `F3_OR, `F3_AND: legal = 1'b1;
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

    // Unsupported words become bubbles
    assign read_rs1_o = instr_valid_i && legal;
    assign read_rs2_o = instr_valid_i && legal && is_r;
    assign wr_en_o    = instr_valid_i && legal;

endmodule

/* register_file.sv */
`include "rv_consts.svh"

module register_file (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   issue_hold_i,

    // ----------------------------------------
    // From decoder
    // ----------------------------------------
    input  logic                   read_rs1_i,
    input  logic                   read_rs2_i,
    input  logic                   wr_en_i,
    input  logic [`REG_IDX_W-1:0]  rs1_idx_i,
    input  logic [`REG_IDX_W-1:0]  rs2_idx_i,
    input  logic [`REG_IDX_W-1:0]  rd_idx_i,

    // ----------------------------------------
    // From writeback
    // ----------------------------------------
    input  logic                   wb_valid_i,
    input  logic [`REG_IDX_W-1:0]  wb_rd_i,
    input  logic [`XLEN-1:0]       wb_data_i,

    // To execute and outside
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o,
    output logic                   issue_o,
    output logic                   stall_o
);

    logic [`XLEN-1:0]  regs [`REG_COUNT];
    logic [`PEND_W-1:0] pend [`REG_COUNT];

    // Source busy when enabled and a write is outstanding
    logic rs1_busy;
    logic rs2_busy;

    // x0 counter never moves, so x0 is never busy
    assign rs1_busy = read_rs1_i && (pend[rs1_idx_i] != '0);
    assign rs2_busy = read_rs2_i && (pend[rs2_idx_i] != '0);

    assign stall_o = rs1_busy || rs2_busy;

    // Operand read, zero when disabled or still pending
    always_comb begin
        rs1_data_o = '0;
        rs2_data_o = '0;
        if (read_rs1_i && !rs1_busy) begin
            rs1_data_o = regs[rs1_idx_i];
        end
        if (read_rs2_i && !rs2_busy) begin
            rs2_data_o = regs[rs2_idx_i];
        end
    end

    // Accept edge: something decoded, nothing blocking
    assign issue_o = (read_rs1_i || read_rs2_i || wr_en_i) && !stall_o && !issue_hold_i;

    // ----------------------------------------
    // Data and scoreboard update
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
                pend[i] <= '0;
            end
        end else begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                // Retire writes data and drops one pending write
                if (wb_valid_i && int'(wb_rd_i) == i) begin
                    regs[i] <= wb_data_i;
                end
                // New claim and retire on the same edge cancel
                if (issue_o && wr_en_i && int'(rd_idx_i) == i) begin
                    if (!(wb_valid_i && int'(wb_rd_i) == i)) begin
                        pend[i] <= pend[i] + 1'b1;
                    end
                end else if (wb_valid_i && int'(wb_rd_i) == i) begin
                    pend[i] <= pend[i] - 1'b1;
                end
            end
        end
    end

endmodule

/* alu_execute.sv */
`include "rv_consts.svh"

module alu_execute
    import rv_pipe_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   issue_i,
    input  alu_op_e                alu_op_i,
    input  logic                   use_imm_i,
    input  logic [`XLEN-1:0]       imm_i,
    input  logic [`XLEN-1:0]       rs1_data_i,
    input  logic [`XLEN-1:0]       rs2_data_i,
    input  logic [`REG_IDX_W-1:0]  rd_idx_i,
    input  logic                   wr_en_i,

    output logic                   ex_valid_o,
    output logic [`REG_IDX_W-1:0]  ex_rd_o,
    output logic [`XLEN-1:0]       ex_data_o
);

    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] result;
    logic             take;

    // Second operand, register or immediate
    assign op_b = use_imm_i ? imm_i : rs2_data_i;

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    always_comb begin
        case (alu_op_i)
            ALU_SUB: result = rs1_data_i - op_b;
            ALU_AND: result = rs1_data_i & op_b;
            ALU_OR:  result = rs1_data_i | op_b;
            ALU_XOR: result = rs1_data_i ^ op_b;
            default: result = rs1_data_i + op_b;
        endcase
    end

    // Only writing instructions occupy a slot
    assign take = issue_i && wr_en_i;

    // Result register, loaded on the accept edge
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= take;
        end
    end

    // Payload holds when nothing is taken
    always_ff @(posedge clk_i) begin
        if (take) begin
            ex_rd_o   <= rd_idx_i;
            ex_data_o <= result;
        end
    end

endmodule

/* writeback_stage.sv */
`include "rv_consts.svh"

module writeback_stage (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   ex_valid_i,
    input  logic [`REG_IDX_W-1:0]  ex_rd_i,
    input  logic [`XLEN-1:0]       ex_data_i,

    output logic                   wb_valid_o,
    output logic [`REG_IDX_W-1:0]  wb_rd_o,
    output logic [`XLEN-1:0]       wb_data_o
);

    // Delay slots, index 0 nearest execute
    logic                  slot_valid [`WB_STAGES];
    logic [`REG_IDX_W-1:0] slot_rd    [`WB_STAGES];
    logic [`XLEN-1:0]      slot_data  [`WB_STAGES];

    // ----------------------------------------
    // Valid bits, cleared on reset
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int s = 0; s < `WB_STAGES; s++) begin
                slot_valid[s] <= 1'b0;
            end
        end else begin
            slot_valid[0] <= ex_valid_i;
            for (int s = 1; s < `WB_STAGES; s++) begin
                slot_valid[s] <= slot_valid[s-1];
            end
        end
    end

    // Payload shifts every cycle, never stops
    always_ff @(posedge clk_i) begin
        slot_rd[0]   <= ex_rd_i;
        slot_data[0] <= ex_data_i;
        for (int s = 1; s < `WB_STAGES; s++) begin
            slot_rd[s]   <= slot_rd[s-1];
            slot_data[s] <= slot_data[s-1];
        end
    end

    // Last slot is the retire port
    assign wb_valid_o = slot_valid[`WB_STAGES-1];
    assign wb_rd_o    = slot_rd[`WB_STAGES-1];
    assign wb_data_o  = slot_data[`WB_STAGES-1];

endmodule

/* int_pipe_top.sv */
`include "rv_consts.svh"

module int_pipe_top
    import rv_pipe_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic [`XLEN-1:0]       instr_i,
    input  logic                   instr_valid_i,
    input  logic                   issue_hold_i,

    output logic                   stall_o,
    output logic                   wb_valid_o,
    output logic [`REG_IDX_W-1:0]  wb_rd_o,
    output logic [`XLEN-1:0]       wb_data_o
);

    // Decode outputs
    logic [`REG_IDX_W-1:0] rs1_idx;
    logic [`REG_IDX_W-1:0] rs2_idx;
    logic [`REG_IDX_W-1:0] rd_idx;
    logic                  rd_read_rs1;
    logic                  rd_read_rs2;
    logic                  wr_en;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic [`XLEN-1:0]      imm;

    // Operands and issue
    logic [`XLEN-1:0]      rs1_data;
    logic [`XLEN-1:0]      rs2_data;
    logic                  issue;

    // Execute result
    logic                  ex_valid;
    logic [`REG_IDX_W-1:0] ex_rd;
    logic [`XLEN-1:0]      ex_data;

    // ----------------------------------------
    // Decode
    // ----------------------------------------
    instr_decoder i_instr_decoder (
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .rs1_idx_o     (rs1_idx),
        .rs2_idx_o     (rs2_idx),
        .rd_idx_o      (rd_idx),
        .read_rs1_o    (rd_read_rs1),
        .read_rs2_o    (rd_read_rs2),
        .wr_en_o       (wr_en),
        .alu_op_o      (alu_op),
        .use_imm_o     (use_imm),
        .imm_o         (imm)
    );

    // Read, scoreboard and issue
    register_file i_register_file (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .issue_hold_i (issue_hold_i),
        .read_rs1_i   (rd_read_rs1),
        .read_rs2_i   (rd_read_rs2),
        .wr_en_i      (wr_en),
        .rs1_idx_i    (rs1_idx),
        .rs2_idx_i    (rs2_idx),
        .rd_idx_i     (rd_idx),
        .wb_valid_i   (wb_valid_o),
        .wb_rd_i      (wb_rd_o),
        .wb_data_i    (wb_data_o),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data),
        .issue_o      (issue),
        .stall_o      (stall_o)
    );

    // ----------------------------------------
    // Execute and retire
    // ----------------------------------------
    alu_execute i_alu_execute (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .issue_i    (issue),
        .alu_op_i   (alu_op),
        .use_imm_i  (use_imm),
        .imm_i      (imm),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rd_idx_i   (rd_idx),
        .wr_en_i    (wr_en),
        .ex_valid_o (ex_valid),
        .ex_rd_o    (ex_rd),
        .ex_data_o  (ex_data)
    );

    // Retire port also feeds the register file
    writeback_stage i_writeback_stage (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .ex_valid_i (ex_valid),
        .ex_rd_i    (ex_rd),
        .ex_data_i  (ex_data),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

/* int_pipe_props.sv */
`include "rv_consts.svh"

module int_pipe_props (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   issue_i,
    input  logic                   wr_en_i,
    input  logic [`REG_IDX_W-1:0]  rd_idx_i,
    input  logic                   wb_valid_i,
    input  logic [`REG_IDX_W-1:0]  wb_rd_i,
    input  logic                   stall_i,
    input  logic [`PEND_W-1:0]     pend_i [`REG_COUNT]
);
    timeunit 1ns;
    timeprecision 1ps;

    // Read by the testbench at the end of the run
    int fail_cnt = 0;

    // Retire only to a register with an outstanding write
    retire_has_claim: assert property (@(posedge clk_i) disable iff (!rst_i)
        wb_valid_i && (wb_rd_i != '0) |-> pend_i[wb_rd_i] != '0)
        else begin
            $error("retire to a register with no pending write");
            fail_cnt++;
        end

    // Full counter takes a new claim only alongside its oldest retire
    claim_never_wraps: assert property (@(posedge clk_i) disable iff (!rst_i)
        issue_i && wr_en_i && (rd_idx_i != '0) && (pend_i[rd_idx_i] == '1)
        |-> wb_valid_i && (wb_rd_i == rd_idx_i))
        else begin
            $error("pending counter would wrap on a new claim");
            fail_cnt++;
        end

    // Nothing issues during a stall so it clears within three edges
    stall_drains: assert property (@(posedge clk_i) disable iff (!rst_i)
        $rose(stall_i) |-> ##[1:3] !stall_i)
        else begin
            $error("stall held longer than the writeback latency");
            fail_cnt++;
        end

endmodule

bind register_file int_pipe_props i_int_pipe_props (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .issue_i    (issue_o),
    .wr_en_i    (wr_en_i),
    .rd_idx_i   (rd_idx_i),
    .wb_valid_i (wb_valid_i),
    .wb_rd_i    (wb_rd_i),
    .stall_i    (stall_o),
    .pend_i     (pend)
);

/* tb_int_pipe.sv */
`include "rv_consts.svh"

module tb_int_pipe
    import rv_arch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INSTR      = 200;
    localparam int TIMEOUT_CYCLES = 4 * NUM_INSTR + 50;

    logic        clk_i = 1'b0;
    logic        rst_i;
    logic [31:0] instr_i;
    logic        instr_valid_i;
    logic        issue_hold_i;
    logic        stall_o;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;

    // Stimulus and model state
    logic [31:0] lfsr_state = 32'ha8125fc8;
    logic [31:0] shadow [`REG_COUNT];
    int          pend_model [`REG_COUNT];
    int          exp_rd_q[$];
    logic [31:0] exp_data_q[$];
    int          exp_cycle_q[$];
    int          edge_no, accepted, retired, checks, errors, cycle_cnt;
    logic        cur_valid, cur_imm_sel, hold, exp_stall, retire_now;
    int          cur_kind, cur_rs1, cur_rs2, cur_rd, retire_rd;
    logic [31:0] cur_imm;
    instr_u      cur_word;

    int_pipe_top i_int_pipe_top (.*);

    always #50 clk_i = ~clk_i;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Kind 0 add, 1 sub, 2 and, 3 or, 4 xor
    function automatic logic [31:0] alu_ref(input int kind, input logic [31:0] a, b);
        case (kind)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            default: return a ^ b;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got, exp);
        errors++;
        $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    endtask

    // Random instruction, registers x0..x7 only so hazards are common
    task automatic make_instr();
        logic [11:0] imm12;
        logic [2:0]  f3;
        cur_kind    = rand_bits(3) % 5;
        cur_imm_sel = rand_bits(1);
        cur_rs1     = rand_bits(3);
        cur_rs2     = rand_bits(3);
        cur_rd      = rand_bits(3);
        imm12       = rand_bits(12);
        // No immediate form of SUB
        if (cur_imm_sel && cur_kind == 1) cur_kind = 0;
        cur_imm = {{20{imm12[11]}}, imm12};
        case (cur_kind)
            2: f3 = `F3_AND;
            3: f3 = `F3_OR;
            4: f3 = `F3_XOR;
            default: f3 = `F3_ADD;
        endcase
        if (cur_imm_sel) begin
            cur_word.i = {imm12, cur_rs1[4:0], f3, cur_rd[4:0], `OPC_OP_IMM};
        end else begin
            cur_word.r = {(cur_kind == 1) ? `F7_SUB : 7'b0, cur_rs2[4:0], cur_rs1[4:0],
                          f3, cur_rd[4:0], `OPC_OP};
        end
    endtask

    // ----------------------------------------
    // One clock cycle: drive, check, update
    // ----------------------------------------
    task automatic run_cycle();
        logic        accept;
        logic [31:0] a, b;
        @(negedge clk_i);
        if (!cur_valid && accepted < NUM_INSTR && rand_bits(3) != 0) begin
            make_instr();
            cur_valid = 1'b1;
        end
        hold          = (rand_bits(3) == 0);
        instr_valid_i = cur_valid;
        instr_i       = cur_word;
        issue_hold_i  = hold;
        #25;
        // Stall expected only on a pending nonzero source
        exp_stall = cur_valid && ((cur_rs1 != 0 && pend_model[cur_rs1] != 0) ||
                    (!cur_imm_sel && cur_rs2 != 0 && pend_model[cur_rs2] != 0));
        checks++;
        if (stall_o !== exp_stall) report_mismatch("stall_o", stall_o, exp_stall);
        retire_now = 1'b0;
        if (exp_cycle_q.size() > 0 && exp_cycle_q[0] == edge_no) begin
            retire_now = 1'b1;
            retire_rd  = exp_rd_q[0];
            checks++;
            if (wb_valid_o !== 1'b1) begin
                report_mismatch("wb_valid_o", wb_valid_o, 1);
            end else begin
                if (wb_rd_o !== exp_rd_q[0][4:0]) report_mismatch("wb_rd_o", wb_rd_o, exp_rd_q[0]);
                if (wb_data_o !== exp_data_q[0]) report_mismatch("wb_data_o", wb_data_o,
                                                                 exp_data_q[0]);
            end
            void'(exp_rd_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_cycle_q.pop_front());
            retired++;
        end else if (wb_valid_o !== 1'b0) begin
            report_mismatch("wb_valid_o", wb_valid_o, 0);
        end
        accept = cur_valid && !exp_stall && !hold;
        @(posedge clk_i);
        edge_no++;
        // Retire drops its claim one edge after it shows on the ports
        if (retire_now && retire_rd != 0) pend_model[retire_rd]--;
        if (accept) begin
            a = shadow[cur_rs1];
            b = cur_imm_sel ? cur_imm : shadow[cur_rs2];
            exp_rd_q.push_back(cur_rd);
            exp_data_q.push_back(alu_ref(cur_kind, a, b));
            exp_cycle_q.push_back(edge_no + 2);
            if (cur_rd != 0) begin
                shadow[cur_rd] = alu_ref(cur_kind, a, b);
                pend_model[cur_rd]++;
            end
            accepted++;
            cur_valid = 1'b0;
        end
    endtask

    task automatic print_summary();
        $display("Summary: accepted=%0d retired=%0d checks=%0d errors=%0d assertion_failures=%0d",
                 accepted, retired, checks, errors,
                 i_int_pipe_top.i_register_file.i_int_pipe_props.fail_cnt);
    endtask

    // Run limit
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles with %0d instructions still expected to retire",
                 cycle_cnt, NUM_INSTR - retired);
        print_summary();
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst_i         = 1'b0;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        issue_hold_i  = 1'b0;
        cur_word      = '0;
        cur_valid     = 1'b0;
        cur_imm_sel   = 1'b0;
        {cur_kind, cur_rs1, cur_rs2, cur_rd} = '0;
        {edge_no, accepted, retired, checks, errors} = '0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            shadow[r]     = '0;
            pend_model[r] = 0;
        end
        // Reset, outputs quiet throughout
        repeat (4) begin
            @(posedge clk_i);
            #25;
            checks++;
            if (wb_valid_o !== 1'b0) report_mismatch("wb_valid_o", wb_valid_o, 0);
            if (stall_o !== 1'b0) report_mismatch("stall_o", stall_o, 0);
        end
        @(negedge clk_i);
        rst_i = 1'b1;
        while (accepted < NUM_INSTR || exp_rd_q.size() > 0) run_cycle();
        // Idle tail, no stray retires
        repeat (4) run_cycle();
        print_summary();
        if (errors == 0 && i_int_pipe_top.i_register_file.i_int_pipe_props.fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* int_pipe_top.f */
+incdir+.
rv_arch_pkg.sv
rv_pipe_pkg.sv
instr_decoder.sv
register_file.sv
alu_execute.sv
writeback_stage.sv
int_pipe_top.sv
int_pipe_props.sv
tb_int_pipe.sv
